// File: Bender.yml
package:
  name: xv_video

sources:
  - rtl/xv_pkg.sv
  - rtl/host_port.sv
  - rtl/raster_scan.sv
  - rtl/vram_share.sv
  - rtl/palette_out.sv
  - rtl/xv_video_top.sv
  - target: simulation
    files:
      - dv/xv_video_tb.sv

// File: dv/xv_video_tb.sv
////////////////////
// testbench for the framebuffer video block
// reference model, concurrent checks, host traffic
////////////////////
`default_nettype none
`timescale 1ns/10ps

module xv_video_tb
    import xv_pkg::*;
();

    localparam int VRAM_AW   = 12;
    localparam int H_VISIBLE = 16;
    localparam int H_TOTAL   = 24;
    localparam int V_VISIBLE = 8;
    localparam int V_TOTAL   = 12;
    localparam int FRAME_PIX = H_VISIBLE * V_VISIBLE;  // words on screen
    localparam int TIMEOUT   = 2000;                   // cycles per wait

    logic       clk;
    logic       reset_i;
    logic       host_valid_i;
    logic       host_wr_i;
    logic       host_xr_i;
    word_t      host_addr_i;
    word_t      host_wdata_i;
    nib_mask_t  host_mask_i;
    logic       host_ready_o;
    word_t      host_rdata_o;
    logic       host_rvalid_o;
    logic       bus_intr_o;
    rgb4_t      red_o;
    rgb4_t      green_o;
    rgb4_t      blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    // reference model
    word_t             vram_m [2**VRAM_AW];
    word_t             pal_m [256];
    logic [INTR_W-1:0] mask_m;
    logic [INTR_W-1:0] status_m;
    logic              intr_exp;            // pulse due this cycle
    int                h_m;                 // scan position
    int                v_m;
    logic              vis_m;
    logic              hs_m;
    logic              vs_m;
    logic [2:0]        de_d;                // raster outputs due, three stages
    logic [2:0]        hs_d;
    logic [2:0]        vs_d;
    logic              rv_1;                // read return pipe
    logic              rv_2;
    word_t             rexp_1;
    word_t             rexp_2;
    logic              video_chk;           // palette and VRAM settled
    logic              frame_ok;            // de count valid since a vsync
    int                de_cnt;
    logic [11:0]       pix_exp;             // 0RGB due at this de cycle

    logic [31:0] seed;
    string       test_name;
    int          err_cnt;
    int          test_base;
    int          test_cnt;

    xv_video_top #(
        .VRAM_AW   (VRAM_AW),
        .H_VISIBLE (H_VISIBLE),
        .H_TOTAL   (H_TOTAL),
        .V_VISIBLE (V_VISIBLE),
        .V_TOTAL   (V_TOTAL)
    ) i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .host_valid_i  (host_valid_i),
        .host_wr_i     (host_wr_i),
        .host_xr_i     (host_xr_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_mask_i   (host_mask_i),
        .host_ready_o  (host_ready_o),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .bus_intr_o    (bus_intr_o),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                  // 100 ns period

    function automatic word_t rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];                 // high bits are the better ones
    endfunction

    function automatic word_t merge_nibbles(word_t old_w, word_t new_w, nib_mask_t m);
        word_t r;
        r = old_w;
        for (int n = 0; n < 4; n++) begin
            if (m[n]) begin
                r[n*4 +: 4] = new_w[n*4 +: 4];
            end
        end
        return r;
    endfunction

    function automatic word_t xr_read_value(word_t addr);
        word_t r;
        r = '0;                             // palette and holes read zero
        if (addr == XR_INTR_MASK) begin
            r[INTR_W-1:0] = mask_m;
        end else if (addr == XR_INTR_STATUS) begin
            r[INTR_W-1:0] = status_m;
        end
        return r;
    endfunction

    assign vis_m = (h_m < H_VISIBLE) && (v_m < V_VISIBLE);
    assign hs_m  = (h_m >= H_VISIBLE) && (h_m <= H_VISIBLE + (H_TOTAL - H_VISIBLE) / 2 - 1);
    assign vs_m  = (v_m >= V_VISIBLE) && (v_m <= V_VISIBLE + (V_TOTAL - V_VISIBLE) / 2 - 1);
    always_comb pix_exp = pal_m[vram_m[de_cnt[VRAM_AW-1:0]][7:0]][11:0];

    always @(posedge clk) begin : ref_model
        logic              acc;
        logic              xr_wr;
        logic [INTR_W-1:0] ev;
        logic [INTR_W-1:0] clr;
        acc   = host_valid_i && host_ready_o && !reset_i;
        xr_wr = acc && host_wr_i && host_xr_i;
        ev    = '0;
        clr   = '0;
        ev[INTR_VBLANK] = (h_m == 0) && (v_m == V_VISIBLE);
        if (xr_wr && host_addr_i == XR_INTR_SET) begin
            ev[INTR_HOST] = host_wdata_i[INTR_HOST];
        end
        if (xr_wr && host_addr_i == XR_INTR_STATUS) begin
            clr = host_wdata_i[INTR_W-1:0];  // write one to clear
        end
        rv_1   <= acc && !host_wr_i;
        rexp_1 <= host_xr_i ? xr_read_value(host_addr_i) : vram_m[host_addr_i[VRAM_AW-1:0]];
        rv_2   <= rv_1;
        rexp_2 <= rexp_1;
        if (acc && host_wr_i && !host_xr_i) begin
            vram_m[host_addr_i[VRAM_AW-1:0]] <= merge_nibbles(
                vram_m[host_addr_i[VRAM_AW-1:0]], host_wdata_i, host_mask_i);
        end
        if (xr_wr && host_addr_i[15:8] == XR_COLOR_BASE[15:8]) begin
            pal_m[host_addr_i[7:0]] <= host_wdata_i;
        end
        if (reset_i) begin
            h_m      <= 0;
            v_m      <= 0;
            mask_m   <= '0;
            status_m <= '0;
            intr_exp <= 1'b0;
            rv_1     <= 1'b0;
            rv_2     <= 1'b0;
            frame_ok <= 1'b0;
            de_cnt   <= 0;
            de_d     <= '0;
            hs_d     <= '0;
            vs_d     <= '0;
        end else begin
            if (h_m == H_TOTAL - 1) begin
                h_m <= 0;
                v_m <= (v_m == V_TOTAL - 1) ? 0 : v_m + 1;
            end else begin
                h_m <= h_m + 1;
            end
            de_d <= {de_d[1:0], vis_m};     // fetch, VRAM, palette, output
            hs_d <= {hs_d[1:0], hs_m};
            vs_d <= {vs_d[1:0], vs_m};
            if (xr_wr && host_addr_i == XR_INTR_MASK) begin
                mask_m <= host_wdata_i[INTR_W-1:0];
            end
            intr_exp <= |(ev & mask_m & ~status_m);  // new and enabled only
            status_m <= (status_m | ev) & ~clr;
            // pixel position recovered from the output side
            if (vsync_o) begin
                frame_ok <= video_chk;
                de_cnt   <= 0;
            end else if (dv_de_o) begin
                de_cnt <= de_cnt + 1;
            end
        end
    end

    task automatic report_mismatch(string what, int unsigned exp, int unsigned act);
        $display("MISMATCH %s: %s expected %0h actual %0h", test_name, what, exp, act);
        err_cnt++;
    endtask

    task automatic report_fault(string what);
        $display("error in %s: %s", test_name, what);
        err_cnt++;
    endtask

    a_reset_quiet : assert property (@(posedge clk)
        reset_i |=> !bus_intr_o && !host_rvalid_o && !dv_de_o && !hsync_o && !vsync_o
                    && ({red_o, green_o, blue_o} == '0))
        else report_fault("outputs not low during or just after reset");

    a_blank_black : assert property (@(posedge clk) disable iff (reset_i)
        !dv_de_o |-> ({red_o, green_o, blue_o} == '0))
        else report_mismatch("colour while blanked", 0, $sampled({red_o, green_o, blue_o}));

    a_raster_timing : assert property (@(posedge clk) disable iff (reset_i)
        {dv_de_o, hsync_o, vsync_o} == {de_d[2], hs_d[2], vs_d[2]})
        else report_mismatch("de/hsync/vsync", $sampled({de_d[2], hs_d[2], vs_d[2]}),
                             $sampled({dv_de_o, hsync_o, vsync_o}));

    a_ready_follows_scan : assert property (@(posedge clk) disable iff (reset_i)
        host_ready_o == !vis_m)
        else report_mismatch("host_ready_o", $sampled(!vis_m), $sampled(host_ready_o));

    a_rvalid_timing : assert property (@(posedge clk) disable iff (reset_i)
        host_rvalid_o == rv_2)
        else report_mismatch("host_rvalid_o", $sampled(rv_2), $sampled(host_rvalid_o));

    a_rdata : assert property (@(posedge clk) disable iff (reset_i)
        rv_2 |-> host_rdata_o == rexp_2)
        else report_mismatch("read data", $sampled(rexp_2), $sampled(host_rdata_o));

    a_intr_pulse : assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_o == intr_exp)
        else report_mismatch("bus_intr_o", $sampled(intr_exp), $sampled(bus_intr_o));

    a_pixel : assert property (@(posedge clk) disable iff (reset_i)
        frame_ok && dv_de_o |-> ({red_o, green_o, blue_o} == pix_exp))
        else report_mismatch("pixel colour", $sampled(pix_exp),
                             $sampled({red_o, green_o, blue_o}));

    task automatic abort_run(string why);
        $display("error in %s: %s", test_name, why);
        $display("Something failed");
        $finish;
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic host_xfer(input logic wr, input logic xr, input word_t addr,
                             input word_t wdata, input nib_mask_t mask);
        logic rdy;
        int   waited;
        host_valid_i = 1'b1;
        host_wr_i    = wr;
        host_xr_i    = xr;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        host_mask_i  = mask;
        rdy          = 1'b0;
        waited       = 0;
        while (!rdy && waited < TIMEOUT) begin
            rdy = host_ready_o;             // ready only moves on rising edges
            @(negedge clk);
            waited++;
        end
        if (!rdy) abort_run("host request never accepted");
    endtask

    task automatic wait_fetch_region();
        int waited;
        waited = 0;
        while (host_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (host_ready_o) abort_run("scanner never started fetching");
    endtask

    task automatic wait_intr_pulse();
        int waited;
        waited = 0;
        while (!bus_intr_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_intr_o) abort_run("no bus interrupt pulse seen");
    endtask

    task automatic wait_frame_checked();
        int waited;
        waited = 0;
        while (!(frame_ok && de_cnt >= FRAME_PIX) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(frame_ok && de_cnt >= FRAME_PIX)) abort_run("no complete frame displayed");
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_base = err_cnt;
    endtask

    task automatic end_test();
        host_valid_i = 1'b0;
        host_wr_i    = 1'b0;
        repeat (3) @(negedge clk);          // let the last read return
        test_cnt++;
        if (err_cnt == test_base) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: FAIL, %0d errors", test_name, err_cnt - test_base);
        end
    endtask

    initial begin
        word_t addr;
        word_t r;
        seed         = 32'h84ad3a55;
        err_cnt      = 0;
        test_cnt     = 0;
        video_chk    = 1'b0;
        reset_i      = 1'b1;
        host_valid_i = 1'b0;
        host_wr_i    = 1'b0;
        host_xr_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        host_mask_i  = '0;

        begin_test("reset");
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        repeat (4) @(negedge clk);
        end_test();

        begin_test("vram_rw");
        for (int a = 0; a < FRAME_PIX; a++) begin
            host_xfer(1'b1, 1'b0, 16'(a), rand_word(), 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            addr = rand_word() % FRAME_PIX;
            r    = rand_word();
            host_xfer(1'b1, 1'b0, addr, rand_word(), r[3:0]);
            host_xfer(1'b0, 1'b0, addr, '0, '0); // read right behind the write
        end
        for (int a = 0; a < FRAME_PIX; a++) begin
            host_xfer(1'b0, 1'b0, 16'(a), '0, '0);
        end
        end_test();

        begin_test("fetch_stall");
        for (int i = 0; i < 3; i++) begin
            wait_fetch_region();
            host_xfer(1'b1, 1'b0, 16'(i + 7), rand_word(), 4'hf);
            host_xfer(1'b0, 1'b0, 16'(i + 7), '0, '0);
            host_valid_i = 1'b0;
        end
        end_test();

        begin_test("frame_colour");
        for (int i = 0; i < 256; i++) begin
            host_xfer(1'b1, 1'b1, XR_COLOR_BASE + 16'(i), rand_word(), 4'hf);
        end
        host_valid_i = 1'b0;
        video_chk    = 1'b1;
        wait_frame_checked();
        end_test();

        begin_test("interrupt");
        host_xfer(1'b1, 1'b1, XR_INTR_MASK, 16'h0001, 4'hf);    // vblank only
        host_xfer(1'b1, 1'b1, XR_INTR_STATUS, 16'h0003, 4'hf);  // drop pending from earlier frames
        host_valid_i = 1'b0;
        wait_intr_pulse();
        host_xfer(1'b0, 1'b1, XR_INTR_STATUS, '0, '0);
        host_xfer(1'b1, 1'b1, XR_INTR_STATUS, 16'h0001, 4'hf);
        host_xfer(1'b0, 1'b1, XR_INTR_STATUS, '0, '0);
        host_xfer(1'b1, 1'b1, XR_INTR_SET, 16'h0002, 4'hf);     // masked off, no pulse
        host_xfer(1'b0, 1'b1, XR_INTR_STATUS, '0, '0);
        host_xfer(1'b0, 1'b1, XR_INTR_MASK, '0, '0);
        end_test();

        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/host_port.sv
////////////////////
// host port, valid/ready requests into VRAM, palette and
// interrupt registers, with two-cycle read return
////////////////////
`default_nettype none
`timescale 1ns/10ps

module host_port
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       host_valid_i,   // request present
    input  wire logic       host_wr_i,      // 1 = write
    input  wire logic       host_xr_i,      // 0 = VRAM, 1 = XR space
    input  wire word_t      host_addr_i,
    input  wire word_t      host_wdata_i,
    input  wire nib_mask_t  host_mask_i,
    input  wire logic       host_grant_i,   // VRAM free this cycle
    input  wire word_t      vram_rdata_i,   // one cycle after granted read
    input  wire logic       vblank_pulse_i,
    output logic            host_ready_o,
    output word_t           host_rdata_o,
    output logic            host_rvalid_o,
    output logic            vram_req_o,
    output logic            vram_wr_o,
    output word_t           vram_addr_o,
    output word_t           vram_wdata_o,
    output nib_mask_t       vram_mask_o,
    output logic            pal_wr_o,
    output color_idx_t      pal_addr_o,
    output word_t           pal_wdata_o,
    output logic            bus_intr_o      // one-cycle pulse
);

    logic              accept;              // transfer this edge
    logic              rd_accept;
    logic              pal_sel;
    logic              mask_sel;
    logic              status_sel;
    logic              set_sel;
    logic [INTR_W-1:0] intr_mask;
    logic [INTR_W-1:0] intr_status;
    logic [INTR_W-1:0] intr_event;
    logic [INTR_W-1:0] intr_clear;
    word_t             xr_rd_data;          // register value at accept
    logic              rd_v1;               // stage 1 of read pipe
    logic              rd_vram1;            // stage 1 source tag
    word_t             xr_data1;

    assign host_ready_o = host_grant_i;     // scanner fetch is the only stall
    assign accept       = host_valid_i & host_ready_o;
    assign rd_accept    = accept & ~host_wr_i;

    // XR decode
    assign pal_sel    = host_xr_i && (host_addr_i[15:8] == XR_COLOR_BASE[15:8]);
    assign mask_sel   = host_xr_i && (host_addr_i == XR_INTR_MASK);
    assign status_sel = host_xr_i && (host_addr_i == XR_INTR_STATUS);
    assign set_sel    = host_xr_i && (host_addr_i == XR_INTR_SET);

    // VRAM side, vram_share gates with the grant
    assign vram_req_o   = host_valid_i & ~host_xr_i;
    assign vram_wr_o    = host_wr_i;
    assign vram_addr_o  = host_addr_i;
    assign vram_wdata_o = host_wdata_i;
    assign vram_mask_o  = host_mask_i;

    // palette write lands on the accept edge
    assign pal_wr_o    = accept & host_wr_i & pal_sel;
    assign pal_addr_o  = host_addr_i[7:0];
    assign pal_wdata_o = host_wdata_i;

    // interrupt events and clears
    always_comb begin
        intr_event              = '0;
        intr_event[INTR_VBLANK] = vblank_pulse_i;
        intr_event[INTR_HOST]   = accept & host_wr_i & set_sel & host_wdata_i[INTR_HOST];
        intr_clear = (accept & host_wr_i & status_sel) ? host_wdata_i[INTR_W-1:0] : '0;
    end

    // XR read value, palette and unmapped read as zero
    always_comb begin
        xr_rd_data = '0;
        if (mask_sel) begin
            xr_rd_data[INTR_W-1:0] = intr_mask;
        end else if (status_sel) begin
            xr_rd_data[INTR_W-1:0] = intr_status;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_mask   <= '0;
            intr_status <= '0;
            bus_intr_o  <= 1'b0;
        end else begin
            if (accept && host_wr_i && mask_sel) begin
                intr_mask <= host_wdata_i[INTR_W-1:0];
            end
            // new, enabled and not already pending
            bus_intr_o  <= |(intr_event & intr_mask & ~intr_status);
            intr_status <= (intr_status | intr_event) & ~intr_clear;
        end
    end

    // read pipe control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_v1         <= 1'b0;
            host_rvalid_o <= 1'b0;
        end else begin
            rd_v1         <= rd_accept;
            host_rvalid_o <= rd_v1;
        end
    end

    // read pipe payload
    always_ff @(posedge clk) begin
        rd_vram1     <= ~host_xr_i;         // tag taken with the request
        xr_data1     <= xr_rd_data;
        host_rdata_o <= rd_vram1 ? vram_rdata_i : xr_data1;
    end

    a_rvalid_has_read : assert property (
        @(posedge clk) disable iff (reset_i)
        host_rvalid_o |-> $past(rd_accept, 2)
    );

endmodule

`default_nettype wire

// File: rtl/palette_out.sv
////////////////////
// palette lookup and video output register
////////////////////
`default_nettype none
`timescale 1ns/10ps

module palette_out
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       pal_wr_i,
    input  wire color_idx_t pal_addr_i,
    input  wire word_t      pal_wdata_i,    // 0RGB
    input  wire color_idx_t pix_index_i,
    input  wire logic       raw_de_i,
    input  wire logic       raw_hs_i,
    input  wire logic       raw_vs_i,
    output rgb4_t           red_o,
    output rgb4_t           green_o,
    output rgb4_t           blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    word_t pal_mem [256];
    word_t lookup;                          // registered palette read
    logic  de1;                             // syncs aligned with lookup
    logic  hs1;
    logic  vs1;

    // write port and lookup port
    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal_mem[pal_addr_i] <= pal_wdata_i;
        end
        lookup <= pal_mem[pix_index_i];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de1     <= 1'b0;
            hs1     <= 1'b0;
            vs1     <= 1'b0;
            dv_de_o <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            de1     <= raw_de_i;
            hs1     <= raw_hs_i;
            vs1     <= raw_vs_i;
            dv_de_o <= de1;
            hsync_o <= hs1;
            vsync_o <= vs1;
            // black outside the display area
            red_o   <= de1 ? lookup[11:8] : '0;
            green_o <= de1 ? lookup[7:4]  : '0;
            blue_o  <= de1 ? lookup[3:0]  : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/raster_scan.sv
////////////////////
// raster scanner, counters, syncs and
// one VRAM fetch per visible pixel
////////////////////
`default_nettype none
`timescale 1ns/10ps

module raster_scan
    import xv_pkg::*;
#(
    parameter int H_VISIBLE = 16,
    parameter int H_TOTAL   = 24,
    parameter int V_VISIBLE = 8,
    parameter int V_TOTAL   = 12,
    parameter int VRAM_AW   = 12
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire word_t          pix_word_i,     // word fetched last cycle
    output logic                fetch_en_o,
    output logic [VRAM_AW-1:0]  fetch_addr_o,
    output color_idx_t          pix_index_o,
    output logic                raw_de_o,
    output logic                raw_hs_o,
    output logic                raw_vs_o,
    output logic                vblank_pulse_o
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // sync runs over the first half of each blanking interval
    localparam int H_SYNC_END = H_VISIBLE + (H_TOTAL - H_VISIBLE) / 2;
    localparam int V_SYNC_END = V_VISIBLE + (V_TOTAL - V_VISIBLE) / 2;

    localparam logic [HW-1:0] H_VIS_C  = HW'(H_VISIBLE);
    localparam logic [HW-1:0] H_LAST_C = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_SE_C   = HW'(H_SYNC_END);
    localparam logic [VW-1:0] V_VIS_C  = VW'(V_VISIBLE);
    localparam logic [VW-1:0] V_LAST_C = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_SE_C   = VW'(V_SYNC_END);

    logic [HW-1:0]      h_cnt;              // pixel in line
    logic [VW-1:0]      v_cnt;              // line in frame
    logic               h_last;
    logic               v_last;
    logic               vis;
    logic               hs;
    logic               vs;
    logic [VRAM_AW-1:0] addr_q;             // running fetch address

    assign h_last = (h_cnt == H_LAST_C);
    assign v_last = (v_cnt == V_LAST_C);
    assign vis    = (h_cnt < H_VIS_C) && (v_cnt < V_VIS_C);
    assign hs     = (h_cnt >= H_VIS_C) && (h_cnt < H_SE_C);
    assign vs     = (v_cnt >= V_VIS_C) && (v_cnt < V_SE_C);

    assign fetch_en_o     = vis;            // combinational from counters
    assign fetch_addr_o   = addr_q;
    assign vblank_pulse_o = (h_cnt == '0) && (v_cnt == V_VIS_C);
    assign pix_index_o    = pix_word_i[7:0]; // low byte picks the colour

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            addr_q <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            // visible lines are back to back, so a plain
            // count gives line * H_VISIBLE + pixel
            if (h_last && v_last) begin
                addr_q <= '0;
            end else if (vis) begin
                addr_q <= addr_q + 1'b1;    // wraps at 2^VRAM_AW
            end
        end
    end

    // one stage to line up with the returned word
    always_ff @(posedge clk) begin
        if (reset_i) begin
            raw_de_o <= 1'b0;
            raw_hs_o <= 1'b0;
            raw_vs_o <= 1'b0;
        end else begin
            raw_de_o <= vis;
            raw_hs_o <= hs;
            raw_vs_o <= vs;
        end
    end

    a_h_in_range : assert property (
        @(posedge clk) disable iff (reset_i)
        h_cnt < HW'(H_TOTAL)
    );

endmodule

`default_nettype wire

// File: rtl/vram_share.sv
////////////////////
// VRAM with nibble-masked writes, scanner before host,
// read data routed back to the requester
////////////////////
`default_nettype none
`timescale 1ns/10ps

module vram_share
    import xv_pkg::*;
#(
    parameter int VRAM_AW = 12
) (
    input  wire logic               clk,
    input  wire logic               fetch_en_i,     // scanner read, always wins
    input  wire logic [VRAM_AW-1:0] fetch_addr_i,
    input  wire logic               vram_req_i,
    input  wire logic               vram_wr_i,
    input  wire word_t              vram_addr_i,
    input  wire word_t              vram_wdata_i,
    input  wire nib_mask_t          vram_mask_i,
    output logic                    host_grant_o,
    output word_t                   pix_word_o,
    output word_t                   vram_rdata_o
);

    word_t              mem [2**VRAM_AW];   // single port array

    logic               host_go;            // host owns the array
    logic               host_we;
    logic               host_rd;
    logic               arr_rd;
    logic [VRAM_AW-1:0] arr_addr;
    word_t              rd_word;
    logic               rd_fetch_q;         // last read was scanner
    logic               rd_host_q;          // last read was host

    assign host_grant_o = ~fetch_en_i;
    assign host_go      = vram_req_i & host_grant_o;
    assign host_we      = host_go & vram_wr_i;
    assign host_rd      = host_go & ~vram_wr_i;
    assign arr_rd       = fetch_en_i | host_rd;
    assign arr_addr     = fetch_en_i ? fetch_addr_i : vram_addr_i[VRAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (host_we) begin
            for (int n = 0; n < 4; n++) begin
                if (vram_mask_i[n]) begin
                    mem[arr_addr][n*4 +: 4] <= vram_wdata_i[n*4 +: 4];
                end
            end
        end
        if (arr_rd) begin
            rd_word <= mem[arr_addr];
        end
        rd_fetch_q <= fetch_en_i;
        rd_host_q  <= host_rd;
    end

    // route to whoever read, the other side sees zero
    assign pix_word_o   = rd_fetch_q ? rd_word : '0;
    assign vram_rdata_o = rd_host_q  ? rd_word : '0;

    // a fetch cycle leaves no host access behind it
    a_scanner_owns : assert property (
        @(posedge clk)
        fetch_en_i |=> (rd_fetch_q && !rd_host_q)
    );

endmodule

`default_nettype wire

// File: rtl/xv_pkg.sv
////////////////////
// video block shared definitions
// widths, XR register map, interrupt bits
////////////////////
`default_nettype none

package xv_pkg;

    // data path
    localparam int WORD_W = 16;                 // host, VRAM and palette word

    typedef logic [WORD_W-1:0] word_t;          // one data word
    typedef logic [3:0]        nib_mask_t;      // write enable per nibble
    typedef logic [7:0]        color_idx_t;     // palette index
    typedef logic [3:0]        rgb4_t;          // one colour channel

    // XR address map
    // palette lives in 0x0000..0x00ff, colour in 0RGB layout
    localparam word_t XR_COLOR_BASE  = 16'h0000;
    localparam word_t XR_INTR_MASK   = 16'h8000; // interrupt enables
    localparam word_t XR_INTR_STATUS = 16'h8001; // pending, write one to clear
    localparam word_t XR_INTR_SET    = 16'h8002; // host event trigger

    // interrupt bits
    localparam int INTR_W      = 2;
    localparam int INTR_VBLANK = 0;             // start of vertical blank
    localparam int INTR_HOST   = 1;             // raised by host write

endpackage

`default_nettype wire

// File: rtl/xv_video_top.sv
////////////////////
// framebuffer video block top level
////////////////////
`default_nettype none
`timescale 1ns/10ps

module xv_video_top
    import xv_pkg::*;
#(
    parameter int VRAM_AW   = 12,
    parameter int H_VISIBLE = 16,
    parameter int H_TOTAL   = 24,
    parameter int V_VISIBLE = 8,
    parameter int V_TOTAL   = 12
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       host_valid_i,
    input  wire logic       host_wr_i,
    input  wire logic       host_xr_i,
    input  wire word_t      host_addr_i,
    input  wire word_t      host_wdata_i,
    input  wire nib_mask_t  host_mask_i,
    output logic            host_ready_o,
    output word_t           host_rdata_o,
    output logic            host_rvalid_o,
    output logic            bus_intr_o,
    output rgb4_t           red_o,
    output rgb4_t           green_o,
    output rgb4_t           blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    // scanner side
    logic               fetch_en;
    logic [VRAM_AW-1:0] fetch_addr;
    word_t              pix_word;
    color_idx_t         pix_index;
    logic               raw_de;
    logic               raw_hs;
    logic               raw_vs;
    logic               vblank_pulse;

    // host side
    logic               host_grant;
    logic               vram_req;
    logic               vram_wr;
    word_t              vram_addr;
    word_t              vram_wdata;
    nib_mask_t          vram_mask;
    word_t              vram_rdata;
    logic               pal_wr;
    color_idx_t         pal_addr;
    word_t              pal_wdata;

    host_port i_host_port (
        .clk            (clk),
        .reset_i        (reset_i),
        .host_valid_i   (host_valid_i),
        .host_wr_i      (host_wr_i),
        .host_xr_i      (host_xr_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .host_mask_i    (host_mask_i),
        .host_grant_i   (host_grant),
        .vram_rdata_i   (vram_rdata),
        .vblank_pulse_i (vblank_pulse),
        .host_ready_o   (host_ready_o),
        .host_rdata_o   (host_rdata_o),
        .host_rvalid_o  (host_rvalid_o),
        .vram_req_o     (vram_req),
        .vram_wr_o      (vram_wr),
        .vram_addr_o    (vram_addr),
        .vram_wdata_o   (vram_wdata),
        .vram_mask_o    (vram_mask),
        .pal_wr_o       (pal_wr),
        .pal_addr_o     (pal_addr),
        .pal_wdata_o    (pal_wdata),
        .bus_intr_o     (bus_intr_o)
    );

    raster_scan #(
        .H_VISIBLE (H_VISIBLE),
        .H_TOTAL   (H_TOTAL),
        .V_VISIBLE (V_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .VRAM_AW   (VRAM_AW)
    ) i_raster_scan (
        .clk            (clk),
        .reset_i        (reset_i),
        .pix_word_i     (pix_word),
        .fetch_en_o     (fetch_en),
        .fetch_addr_o   (fetch_addr),
        .pix_index_o    (pix_index),
        .raw_de_o       (raw_de),
        .raw_hs_o       (raw_hs),
        .raw_vs_o       (raw_vs),
        .vblank_pulse_o (vblank_pulse)
    );

    vram_share #(
        .VRAM_AW (VRAM_AW)
    ) i_vram_share (
        .clk          (clk),
        .fetch_en_i   (fetch_en),
        .fetch_addr_i (fetch_addr),
        .vram_req_i   (vram_req),
        .vram_wr_i    (vram_wr),
        .vram_addr_i  (vram_addr),
        .vram_wdata_i (vram_wdata),
        .vram_mask_i  (vram_mask),
        .host_grant_o (host_grant),
        .pix_word_o   (pix_word),
        .vram_rdata_o (vram_rdata)
    );

    palette_out i_palette_out (
        .clk         (clk),
        .reset_i     (reset_i),
        .pal_wr_i    (pal_wr),
        .pal_addr_i  (pal_addr),
        .pal_wdata_i (pal_wdata),
        .pix_index_i (pix_index),
        .raw_de_i    (raw_de),
        .raw_hs_i    (raw_hs),
        .raw_vs_i    (raw_vs),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o)
    );

endmodule

`default_nettype wire

// File: xv_video.f
rtl/xv_pkg.sv
rtl/host_port.sv
rtl/raster_scan.sv
rtl/vram_share.sv
rtl/palette_out.sv
rtl/xv_video_top.sv
dv/xv_video_tb.sv
